// File: vga_macros.svh
`ifndef VGA_MACROS_SVH
`define VGA_MACROS_SVH

// Peripheral bus widths
`define VGA_BUS_ADDRESS_BITS 24
`define VGA_BUS_DATA_BITS 32
`define VGA_REG_OFFSET_BITS 12

// Frame buffer word address width
`define VGA_ADDRESS_BITS 13

// Register map, block select in address bits 23:12
`define VGA_CONFIG_BLOCK 12'h010
`define VGA_REG_H_VISIBLE 12'h000
`define VGA_REG_H_FRONT 12'h004
`define VGA_REG_H_SYNC 12'h008
`define VGA_REG_H_WHOLE 12'h00C
`define VGA_REG_V_VISIBLE 12'h010
`define VGA_REG_V_FRONT 12'h014
`define VGA_REG_V_SYNC 12'h018
`define VGA_REG_V_WHOLE 12'h01C
`define VGA_REG_CONFIG 12'h020

// Reset timing is 800x600 at 60 Hz
`define VGA_DEFAULT_H_VISIBLE 11'd799
`define VGA_DEFAULT_H_FRONT 11'd839
`define VGA_DEFAULT_H_SYNC 11'd967
`define VGA_DEFAULT_H_WHOLE 11'd1055
`define VGA_DEFAULT_V_VISIBLE 10'd599
`define VGA_DEFAULT_V_FRONT 10'd600
`define VGA_DEFAULT_V_SYNC 10'd604
`define VGA_DEFAULT_V_WHOLE 10'd627
`define VGA_DEFAULT_CONFIG 10'h0AA

// Raw mode address fields and colour fields per word
`define VGA_VERTICAL_BITS 7
`define VGA_HORIZONTAL_BITS 4
`define VGA_MAX_SUB_PIXEL 4

`endif

// File: vgaBusPkg.sv
`include "vga_macros.svh"

package vgaBusPkg;

	// Full peripheral bus address, block select plus offset
	typedef logic [`VGA_BUS_ADDRESS_BITS-1:0] busAddressT;

	// Register offset inside the config block
	typedef logic [`VGA_REG_OFFSET_BITS-1:0] regOffsetT;

	typedef logic [`VGA_BUS_DATA_BITS-1:0] busDataT;

	// One enable per byte lane of busDataT
	typedef logic [`VGA_BUS_DATA_BITS/8-1:0] byteSelectT;

endpackage

// File: vgaVideoPkg.sv
`include "vga_macros.svh"

package vgaVideoPkg;

	// Scan counters and the timing compare values
	typedef logic [10:0] hCountT;
	typedef logic [9:0] vCountT;

	// Stretch factor minus one
	typedef logic [3:0] pixelSizeT;

	// Codes 2 and 3 are reported as raw by the register bank
	typedef enum logic [1:0] {
		drawModeRaw = 2'd0,
		drawModeTight = 2'd1
	} drawModeE;

	// Bits 3:0 horizontal size, 7:4 vertical size, 9:8 draw mode
	typedef logic [9:0] displayConfigT;

	typedef logic [2:0] subPixelT;
	typedef logic [17:0] wordIndexT;
	typedef logic [`VGA_ADDRESS_BITS-1:0] memAddressT;
	typedef logic [31:0] memWordT;

	// b in 5:4, g in 3:2, r in 1:0
	typedef logic [5:0] pixelColourT;

endpackage

// File: timingConfigIf.sv
`timescale 1ns/1ps

interface timingConfigIf;

	vgaVideoPkg::hCountT hVisible;
	vgaVideoPkg::hCountT hFront;
	vgaVideoPkg::hCountT hSync;
	vgaVideoPkg::hCountT hWhole;

	// Vertical values are in lines
	vgaVideoPkg::vCountT vVisible;
	vgaVideoPkg::vCountT vFront;
	vgaVideoPkg::vCountT vSync;
	vgaVideoPkg::vCountT vWhole;

	modport registers (
		output hVisible, hFront, hSync, hWhole,
		output vVisible, vFront, vSync, vWhole
	);

	modport timing (
		input hVisible, hFront, hSync, hWhole,
		input vVisible, vFront, vSync, vWhole
	);

endinterface

// File: vgaRegisterBank.sv
`timescale 1ns/1ps
`include "vga_macros.svh"

module vgaRegisterBank (
	input logic vga_clk,
	input logic reset,
	input logic peripheralBus_we,
	input logic peripheralBus_oe,
	input vgaBusPkg::busAddressT peripheralBus_address,
	input vgaBusPkg::byteSelectT peripheralBus_byteSelect,
	input vgaBusPkg::busDataT peripheralBus_dataWrite,
	output vgaBusPkg::busDataT peripheralBus_dataRead,
	output logic requestOutput,
	output vgaVideoPkg::pixelSizeT horizontalPixelSize,
	output vgaVideoPkg::pixelSizeT verticalPixelSize,
	output vgaVideoPkg::drawModeE drawMode,
	timingConfigIf.registers timing
);

	vgaVideoPkg::hCountT hVisibleReg, hFrontReg, hSyncReg, hWholeReg;
	vgaVideoPkg::vCountT vVisibleReg, vFrontReg, vSyncReg, vWholeReg;
	vgaVideoPkg::displayConfigT configReg;
	logic blockSelected;
	vgaBusPkg::regOffsetT offset;

	assign blockSelected = peripheralBus_address[23:12] == `VGA_CONFIG_BLOCK;
	assign offset = peripheralBus_address[11:0];

	// Merge enabled byte lanes into the current value
	function automatic vgaBusPkg::busDataT maskedWrite(input vgaBusPkg::busDataT current);
		vgaBusPkg::busDataT result;
		result = current;
		for (int lane = 0; lane < $bits(vgaBusPkg::byteSelectT); lane++) begin
			if (peripheralBus_byteSelect[lane])
				result[lane*8 +: 8] = peripheralBus_dataWrite[lane*8 +: 8];
		end
		return result;
	endfunction

	always_ff @(posedge vga_clk) begin
		if (reset) begin
			hVisibleReg <= `VGA_DEFAULT_H_VISIBLE;
			hFrontReg <= `VGA_DEFAULT_H_FRONT;
			hSyncReg <= `VGA_DEFAULT_H_SYNC;
			hWholeReg <= `VGA_DEFAULT_H_WHOLE;
			vVisibleReg <= `VGA_DEFAULT_V_VISIBLE;
			vFrontReg <= `VGA_DEFAULT_V_FRONT;
			vSyncReg <= `VGA_DEFAULT_V_SYNC;
			vWholeReg <= `VGA_DEFAULT_V_WHOLE;
			configReg <= `VGA_DEFAULT_CONFIG;
		end else if (peripheralBus_we && blockSelected) begin
			// Upper bits of each merged word fall away in the cast
			case (offset)
				`VGA_REG_H_VISIBLE: hVisibleReg <= vgaVideoPkg::hCountT'(maskedWrite(32'(hVisibleReg)));
				`VGA_REG_H_FRONT: hFrontReg <= vgaVideoPkg::hCountT'(maskedWrite(32'(hFrontReg)));
				`VGA_REG_H_SYNC: hSyncReg <= vgaVideoPkg::hCountT'(maskedWrite(32'(hSyncReg)));
				`VGA_REG_H_WHOLE: hWholeReg <= vgaVideoPkg::hCountT'(maskedWrite(32'(hWholeReg)));
				`VGA_REG_V_VISIBLE: vVisibleReg <= vgaVideoPkg::vCountT'(maskedWrite(32'(vVisibleReg)));
				`VGA_REG_V_FRONT: vFrontReg <= vgaVideoPkg::vCountT'(maskedWrite(32'(vFrontReg)));
				`VGA_REG_V_SYNC: vSyncReg <= vgaVideoPkg::vCountT'(maskedWrite(32'(vSyncReg)));
				`VGA_REG_V_WHOLE: vWholeReg <= vgaVideoPkg::vCountT'(maskedWrite(32'(vWholeReg)));
				`VGA_REG_CONFIG: configReg <= vgaVideoPkg::displayConfigT'(maskedWrite(32'(configReg)));
				default: ;
			endcase
		end
	end

	// Read-back is combinational, all ones when nothing answers
	always_comb begin
		requestOutput = 1'b0;
		peripheralBus_dataRead = '1;
		if (peripheralBus_oe && blockSelected) begin
			requestOutput = 1'b1;
			case (offset)
				`VGA_REG_H_VISIBLE: peripheralBus_dataRead = 32'(hVisibleReg);
				`VGA_REG_H_FRONT: peripheralBus_dataRead = 32'(hFrontReg);
				`VGA_REG_H_SYNC: peripheralBus_dataRead = 32'(hSyncReg);
				`VGA_REG_H_WHOLE: peripheralBus_dataRead = 32'(hWholeReg);
				`VGA_REG_V_VISIBLE: peripheralBus_dataRead = 32'(vVisibleReg);
				`VGA_REG_V_FRONT: peripheralBus_dataRead = 32'(vFrontReg);
				`VGA_REG_V_SYNC: peripheralBus_dataRead = 32'(vSyncReg);
				`VGA_REG_V_WHOLE: peripheralBus_dataRead = 32'(vWholeReg);
				`VGA_REG_CONFIG: peripheralBus_dataRead = 32'(configReg);
				default: requestOutput = 1'b0;
			endcase
		end
	end

	assign timing.hVisible = hVisibleReg;
	assign timing.hFront = hFrontReg;
	assign timing.hSync = hSyncReg;
	assign timing.hWhole = hWholeReg;
	assign timing.vVisible = vVisibleReg;
	assign timing.vFront = vFrontReg;
	assign timing.vSync = vSyncReg;
	assign timing.vWhole = vWholeReg;

	assign horizontalPixelSize = configReg[3:0];
	assign verticalPixelSize = configReg[7:4];

	// Palette and sprite codes fall back to raw
	assign drawMode = (configReg[9:8] == 2'd1) ? vgaVideoPkg::drawModeTight
		: vgaVideoPkg::drawModeRaw;

endmodule

// File: vgaSyncGenerator.sv
`timescale 1ns/1ps

module vgaSyncGenerator (
	input logic vga_clk,
	input logic reset,
	timingConfigIf.timing timing,
	output logic lineEnd,
	output logic inHorizontalVisible,
	output logic inVerticalVisible,
	output logic vga_hsync,
	output logic vga_vsync
);

	vgaVideoPkg::hCountT hCount;
	vgaVideoPkg::vCountT vCount;
	logic frameEnd;

	assign lineEnd = hCount == timing.hWhole;
	assign frameEnd = vCount == timing.vWhole;

	// Pixel clock counter, a line is hWhole+1 clocks
	always_ff @(posedge vga_clk) begin
		if (reset) begin
			hCount <= '0;
			inHorizontalVisible <= 1'b1;
			vga_hsync <= 1'b1;
		end else begin
			if (lineEnd)
				hCount <= '0;
			else
				hCount <= hCount + 1'b1;

			if (hCount == timing.hVisible)
				inHorizontalVisible <= 1'b0;
			else if (lineEnd)
				inHorizontalVisible <= 1'b1;

			// Sync is active low between front porch end and pulse end
			if (hCount == timing.hFront)
				vga_hsync <= 1'b0;
			else if (hCount == timing.hSync)
				vga_hsync <= 1'b1;
		end
	end

	// Line counter, same compares but only at the end of each line
	always_ff @(posedge vga_clk) begin
		if (reset) begin
			vCount <= '0;
			inVerticalVisible <= 1'b1;
			vga_vsync <= 1'b1;
		end else if (lineEnd) begin
			if (frameEnd)
				vCount <= '0;
			else
				vCount <= vCount + 1'b1;

			if (vCount == timing.vVisible)
				inVerticalVisible <= 1'b0;
			else if (frameEnd)
				inVerticalVisible <= 1'b1;

			if (vCount == timing.vFront)
				vga_vsync <= 1'b0;
			else if (vCount == timing.vSync)
				vga_vsync <= 1'b1;
		end
	end

endmodule

// File: vgaPixelFetch.sv
`timescale 1ns/1ps
`include "vga_macros.svh"

module vgaPixelFetch (
	input logic vga_clk,
	input logic reset,
	input logic inHorizontalVisible,
	input logic inVerticalVisible,
	input logic lineEnd,
	input vgaVideoPkg::pixelSizeT horizontalPixelSize,
	input vgaVideoPkg::pixelSizeT verticalPixelSize,
	input vgaVideoPkg::drawModeE drawMode,
	input vgaVideoPkg::memWordT vga_data,
	output vgaVideoPkg::memAddressT vga_address,
	output vgaVideoPkg::pixelColourT pixelColour
);

	vgaVideoPkg::pixelSizeT hStretch;
	vgaVideoPkg::pixelSizeT vStretch;
	vgaVideoPkg::subPixelT fieldIndex;
	vgaVideoPkg::hCountT hWord;
	vgaVideoPkg::vCountT row;
	vgaVideoPkg::wordIndexT wordIndex;
	vgaVideoPkg::memAddressT rawAddress;
	vgaVideoPkg::memAddressT tightAddress;
	logic fieldDone;
	logic wordDone;

	assign fieldDone = hStretch == horizontalPixelSize;
	assign wordDone = fieldDone && (fieldIndex == vgaVideoPkg::subPixelT'(`VGA_MAX_SUB_PIXEL));

	// Horizontal stepping, each field held for horizontalPixelSize+1 clocks
	always_ff @(posedge vga_clk) begin
		if (reset || !inHorizontalVisible) begin
			hStretch <= '0;
			fieldIndex <= '0;
			hWord <= '0;
		end else if (fieldDone) begin
			hStretch <= '0;
			if (wordDone) begin
				fieldIndex <= '0;
				hWord <= hWord + 1'b1;
			end else begin
				fieldIndex <= fieldIndex + 1'b1;
			end
		end else begin
			hStretch <= hStretch + 1'b1;
		end
	end

	// Running word index for tight mode, held through horizontal blanking
	always_ff @(posedge vga_clk) begin
		if (reset || !inVerticalVisible)
			wordIndex <= '0;
		else if (inHorizontalVisible && wordDone)
			wordIndex <= wordIndex + 1'b1;
	end

	// Row advances once per verticalPixelSize+1 lines
	always_ff @(posedge vga_clk) begin
		if (reset || !inVerticalVisible) begin
			row <= '0;
			vStretch <= '0;
		end else if (lineEnd) begin
			if (vStretch == verticalPixelSize) begin
				row <= row + 1'b1;
				vStretch <= '0;
			end else begin
				vStretch <= vStretch + 1'b1;
			end
		end
	end

	// Word addresses, low two bits select a byte so they stay zero
	assign rawAddress = {row[`VGA_VERTICAL_BITS-1:0], hWord[`VGA_HORIZONTAL_BITS-1:0], 2'b00};
	assign tightAddress = {wordIndex[`VGA_ADDRESS_BITS-3:0], 2'b00};

	always_ff @(posedge vga_clk) begin
		case (drawMode)
			vgaVideoPkg::drawModeTight: vga_address <= tightAddress;
			default: vga_address <= rawAddress;
		endcase
	end

	// Field 0 sits in the lowest bits of the word
	always_comb begin
		case (fieldIndex)
			3'd0: pixelColour = vga_data[5:0];
			3'd1: pixelColour = vga_data[11:6];
			3'd2: pixelColour = vga_data[17:12];
			3'd3: pixelColour = vga_data[23:18];
			3'd4: pixelColour = vga_data[29:24];
			default: pixelColour = vga_data[5:0];
		endcase
	end

endmodule

// File: vgaTop.sv
`timescale 1ns/1ps

module vgaTop (
	input logic vga_clk,
	input logic reset,
	input logic peripheralBus_we,
	input logic peripheralBus_oe,
	input vgaBusPkg::busAddressT peripheralBus_address,
	input vgaBusPkg::byteSelectT peripheralBus_byteSelect,
	input vgaBusPkg::busDataT peripheralBus_dataWrite,
	output vgaBusPkg::busDataT peripheralBus_dataRead,
	output logic requestOutput,
	output vgaVideoPkg::memAddressT vga_address,
	input vgaVideoPkg::memWordT vga_data,
	output logic [1:0] vga_r,
	output logic [1:0] vga_g,
	output logic [1:0] vga_b,
	output logic vga_hsync,
	output logic vga_vsync
);

	vgaVideoPkg::pixelSizeT horizontalPixelSize;
	vgaVideoPkg::pixelSizeT verticalPixelSize;
	vgaVideoPkg::drawModeE drawMode;
	vgaVideoPkg::pixelColourT pixelColour;
	logic inHorizontalVisible;
	logic inVerticalVisible;
	logic lineEnd;

	timingConfigIf timingBus ();

	vgaRegisterBank u_registerBank (
		.vga_clk(vga_clk),
		.reset(reset),
		.peripheralBus_we(peripheralBus_we),
		.peripheralBus_oe(peripheralBus_oe),
		.peripheralBus_address(peripheralBus_address),
		.peripheralBus_byteSelect(peripheralBus_byteSelect),
		.peripheralBus_dataWrite(peripheralBus_dataWrite),
		.peripheralBus_dataRead(peripheralBus_dataRead),
		.requestOutput(requestOutput),
		.horizontalPixelSize(horizontalPixelSize),
		.verticalPixelSize(verticalPixelSize),
		.drawMode(drawMode),
		.timing(timingBus.registers)
	);

	vgaSyncGenerator u_syncGenerator (
		.vga_clk(vga_clk),
		.reset(reset),
		.timing(timingBus.timing),
		.lineEnd(lineEnd),
		.inHorizontalVisible(inHorizontalVisible),
		.inVerticalVisible(inVerticalVisible),
		.vga_hsync(vga_hsync),
		.vga_vsync(vga_vsync)
	);

	vgaPixelFetch u_pixelFetch (
		.vga_clk(vga_clk),
		.reset(reset),
		.inHorizontalVisible(inHorizontalVisible),
		.inVerticalVisible(inVerticalVisible),
		.lineEnd(lineEnd),
		.horizontalPixelSize(horizontalPixelSize),
		.verticalPixelSize(verticalPixelSize),
		.drawMode(drawMode),
		.vga_data(vga_data),
		.vga_address(vga_address),
		.pixelColour(pixelColour)
	);

	// 2 bits per channel
	assign vga_r = pixelColour[1:0];
	assign vga_g = pixelColour[3:2];
	assign vga_b = pixelColour[5:4];

endmodule

// File: vgaTb.sv
`timescale 1ns/1ps
`include "vga_macros.svh"

module vgaTb;

	// One table row: timing, config word, expected line, sync low and frame clocks
	typedef struct packed {
		vgaVideoPkg::hCountT hVisible;
		vgaVideoPkg::hCountT hFront;
		vgaVideoPkg::hCountT hSync;
		vgaVideoPkg::hCountT hWhole;
		vgaVideoPkg::vCountT vVisible;
		vgaVideoPkg::vCountT vFront;
		vgaVideoPkg::vCountT vSync;
		vgaVideoPkg::vCountT vWhole;
		vgaVideoPkg::displayConfigT displayConfig;
		int lineLen;
		int lowLen;
		int frameLen;
	} stimRowT;

	logic vga_clk;
	logic reset;
	logic peripheralBus_we;
	logic peripheralBus_oe;
	vgaBusPkg::busAddressT peripheralBus_address;
	vgaBusPkg::byteSelectT peripheralBus_byteSelect;
	vgaBusPkg::busDataT peripheralBus_dataWrite;
	vgaBusPkg::busDataT peripheralBus_dataRead;
	logic requestOutput;
	vgaVideoPkg::memAddressT vga_address;
	vgaVideoPkg::memWordT vga_data;
	logic [1:0] vga_r;
	logic [1:0] vga_g;
	logic [1:0] vga_b;
	logic vga_hsync;
	logic vga_vsync;

	stimRowT stimTable [4];
	int watchdogCycles = 0;

	vgaTop u_dut (
		.vga_clk(vga_clk),
		.reset(reset),
		.peripheralBus_we(peripheralBus_we),
		.peripheralBus_oe(peripheralBus_oe),
		.peripheralBus_address(peripheralBus_address),
		.peripheralBus_byteSelect(peripheralBus_byteSelect),
		.peripheralBus_dataWrite(peripheralBus_dataWrite),
		.peripheralBus_dataRead(peripheralBus_dataRead),
		.requestOutput(requestOutput),
		.vga_address(vga_address),
		.vga_data(vga_data),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b),
		.vga_hsync(vga_hsync),
		.vga_vsync(vga_vsync)
	);

	always #50 vga_clk = ~vga_clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Frame buffer contents, every address bit reaches the pattern
	function automatic vgaVideoPkg::memWordT memWord(input vgaVideoPkg::memAddressT address);
		return xorshift(xorshift(32'h2c96 ^ {address, 3'b000, address, 3'b000}));
	endfunction

	assign vga_data = memWord(vga_address);

	task automatic stopRun();
		$display("Test FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkData(input string name, input vgaBusPkg::busDataT actual,
		input vgaBusPkg::busDataT expected);
		if (actual !== expected) begin
			$display("FAIL time=%0t %s: got %h, expected %h", $time, name, actual, expected);
			stopRun();
		end
	endtask

	task automatic checkFlag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("FAIL time=%0t %s: got %b, expected %b", $time, name, actual, expected);
			stopRun();
		end
	endtask

	task automatic checkCount(input string name, input int actual, input int expected);
		if (actual != expected) begin
			$display("FAIL time=%0t %s: got %0d, expected %0d", $time, name, actual, expected);
			stopRun();
		end
	endtask

	task automatic checkAddress(input string name, input vgaVideoPkg::memAddressT actual,
		input vgaVideoPkg::memAddressT expected);
		if (actual !== expected) begin
			$display("FAIL time=%0t %s: got %h, expected %h", $time, name, actual, expected);
			stopRun();
		end
	endtask

	task automatic checkColour(input string name, input vgaVideoPkg::pixelColourT actual,
		input vgaVideoPkg::pixelColourT expected);
		if (actual !== expected) begin
			$display("FAIL time=%0t %s: got %h, expected %h", $time, name, actual, expected);
			stopRun();
		end
	endtask

	task automatic applyReset();
		@(posedge vga_clk);
		reset <= 1'b1;
		repeat (2) @(posedge vga_clk);
		reset <= 1'b0;
	endtask

	task automatic busWrite(input vgaBusPkg::regOffsetT offset, input vgaBusPkg::byteSelectT lanes,
		input vgaBusPkg::busDataT data);
		@(posedge vga_clk);
		peripheralBus_we <= 1'b1;
		peripheralBus_address <= {`VGA_CONFIG_BLOCK, offset};
		peripheralBus_byteSelect <= lanes;
		peripheralBus_dataWrite <= data;
		@(posedge vga_clk);
		peripheralBus_we <= 1'b0;
	endtask

	// Read data is combinational, so it is sampled at the falling edge
	task automatic readCheck(input vgaBusPkg::busAddressT address, input logic enable,
		input vgaBusPkg::busDataT expData, input logic expRequest);
		@(posedge vga_clk);
		peripheralBus_oe <= enable;
		peripheralBus_address <= address;
		@(negedge vga_clk);
		checkData("peripheralBus_dataRead", peripheralBus_dataRead, expData);
		checkFlag("requestOutput", requestOutput, expRequest);
		@(posedge vga_clk);
		peripheralBus_oe <= 1'b0;
	endtask

	task automatic checkDefaults();
		vgaBusPkg::regOffsetT offsets [9];
		vgaBusPkg::busDataT values [9];
		offsets = '{`VGA_REG_H_VISIBLE, `VGA_REG_H_FRONT, `VGA_REG_H_SYNC, `VGA_REG_H_WHOLE,
			`VGA_REG_V_VISIBLE, `VGA_REG_V_FRONT, `VGA_REG_V_SYNC, `VGA_REG_V_WHOLE,
			`VGA_REG_CONFIG};
		values = '{32'd799, 32'd839, 32'd967, 32'd1055, 32'd599, 32'd600, 32'd604, 32'd627,
			32'h0AA};
		for (int i = 0; i < 9; i++)
			readCheck({`VGA_CONFIG_BLOCK, offsets[i]}, 1'b1, values[i], 1'b1);
		// Unmapped offset, foreign block, and oe low
		readCheck({`VGA_CONFIG_BLOCK, 12'h024}, 1'b1, '1, 1'b0);
		readCheck({12'h011, `VGA_REG_H_VISIBLE}, 1'b1, '1, 1'b0);
		readCheck({`VGA_CONFIG_BLOCK, `VGA_REG_H_WHOLE}, 1'b0, '1, 1'b0);
	endtask

	task automatic checkByteLanes();
		busWrite(`VGA_REG_H_WHOLE, 4'b0001, 32'hFFFF_FF12);
		readCheck({`VGA_CONFIG_BLOCK, `VGA_REG_H_WHOLE}, 1'b1, 32'h0000_0412, 1'b1);
		busWrite(`VGA_REG_H_WHOLE, 4'b1110, 32'hFFFF_FFFF);
		readCheck({`VGA_CONFIG_BLOCK, `VGA_REG_H_WHOLE}, 1'b1, 32'h0000_0712, 1'b1);
		busWrite(`VGA_REG_CONFIG, 4'b0010, 32'h0000_FF00);
		readCheck({`VGA_CONFIG_BLOCK, `VGA_REG_CONFIG}, 1'b1, 32'h0000_03AA, 1'b1);
	endtask

	// hWhole goes first so the running counter never passes it
	task automatic programRow(input stimRowT row);
		busWrite(`VGA_REG_H_WHOLE, 4'hF, 32'(row.hWhole));
		busWrite(`VGA_REG_H_VISIBLE, 4'hF, 32'(row.hVisible));
		busWrite(`VGA_REG_H_FRONT, 4'hF, 32'(row.hFront));
		busWrite(`VGA_REG_H_SYNC, 4'hF, 32'(row.hSync));
		busWrite(`VGA_REG_V_WHOLE, 4'hF, 32'(row.vWhole));
		busWrite(`VGA_REG_V_VISIBLE, 4'hF, 32'(row.vVisible));
		busWrite(`VGA_REG_V_FRONT, 4'hF, 32'(row.vFront));
		busWrite(`VGA_REG_V_SYNC, 4'hF, 32'(row.vSync));
		busWrite(`VGA_REG_CONFIG, 4'hF, 32'(row.displayConfig));
		readCheck({`VGA_CONFIG_BLOCK, `VGA_REG_CONFIG}, 1'b1, 32'(row.displayConfig), 1'b1);
	endtask

	// Expected colour and address at line and pixel count of the scan
	task automatic checkPixel(input stimRowT row, input int line, input int count);
		int size;
		int word;
		int rowIndex;
		vgaVideoPkg::memAddressT expAddress;
		size = int'(row.displayConfig[3:0]) + 1;
		checkColour("pixelColour", {vga_b, vga_g, vga_r},
			vgaVideoPkg::pixelColourT'(vga_data >> (6 * ((count / size) % 5))));
		if (count >= 1) begin
			// Address is registered, so it reflects the previous pixel
			word = (count - 1) / (5 * size);
			if (row.displayConfig[9:8] == 2'd1) begin
				word = line * ((int'(row.hVisible) + 1) / (5 * size)) + word;
				expAddress = vgaVideoPkg::memAddressT'(word << 2);
			end else begin
				rowIndex = line / (int'(row.displayConfig[7:4]) + 1);
				expAddress = {rowIndex[`VGA_VERTICAL_BITS-1:0],
					word[`VGA_HORIZONTAL_BITS-1:0], 2'b00};
			end
			checkAddress("vga_address", vga_address, expAddress);
		end
	endtask

	task automatic measureFrame(input stimRowT row);
		int cycle;
		int lastFall;
		int lastEdge;
		int line;
		int count;
		logic prevH;
		logic prevV;
		logic frameDone;
		prevV = 1'b1;
		cycle = 0;
		frameDone = 1'b0;
		while (!frameDone) begin
			@(negedge vga_clk);
			cycle++;
			frameDone = prevV && !vga_vsync;
			prevV = vga_vsync;
			if (!frameDone && cycle > 2 * row.frameLen) begin
				$display("No falling vsync edge arrived within two frames");
				stopRun();
			end
		end
		// vsync falls as the line after the front porch begins
		line = int'(row.vFront) + 1;
		count = 0;
		cycle = 0;
		lastFall = -1;
		lastEdge = 0;
		prevH = vga_hsync;
		prevV = vga_vsync;
		frameDone = 1'b0;
		while (!frameDone) begin
			if (line <= int'(row.vVisible) && count <= int'(row.hVisible))
				checkPixel(row, line, count);
			@(negedge vga_clk);
			cycle++;
			if (count == int'(row.hWhole)) begin
				count = 0;
				line = (line == int'(row.vWhole)) ? 0 : line + 1;
			end else begin
				count++;
			end
			if (prevH && !vga_hsync) begin
				if (lastFall >= 0)
					checkCount("vga_hsync period", cycle - lastFall, row.lineLen);
				lastFall = cycle;
				lastEdge = cycle;
			end else if (!prevH && vga_hsync && lastFall >= 0) begin
				checkCount("vga_hsync low width", cycle - lastFall, row.lowLen);
			end
			prevH = vga_hsync;
			if (cycle - lastEdge > row.lineLen + 1) begin
				$display("No falling hsync edge arrived within a line");
				stopRun();
			end
			if (prevV && !vga_vsync) begin
				checkCount("vga_vsync period", cycle, row.frameLen);
				frameDone = 1'b1;
			end else if (cycle > row.frameLen) begin
				$display("No falling vsync edge arrived within a frame");
				stopRun();
			end
			prevV = vga_vsync;
		end
	endtask

	initial begin
		wait (watchdogCycles > 0);
		repeat (watchdogCycles) @(posedge vga_clk);
		$display("Watchdog expired before all table rows were measured");
		stopRun();
	end

	initial begin
		int budget;
		vga_clk = 1'b0;
		reset = 1'b1;
		peripheralBus_we = 1'b0;
		peripheralBus_oe = 1'b0;
		peripheralBus_address = '0;
		peripheralBus_byteSelect = '0;
		peripheralBus_dataWrite = '0;
		// Codes 2 and 3 in the last two rows must act as raw
		stimTable[0] = '{11'd39, 11'd43, 11'd49, 11'd55, 10'd9, 10'd11, 10'd13, 10'd15,
			10'h010, 56, 6, 896};
		stimTable[1] = '{11'd29, 11'd33, 11'd37, 11'd41, 10'd7, 10'd9, 10'd10, 10'd12,
			10'h101, 42, 4, 546};
		stimTable[2] = '{11'd59, 11'd62, 11'd70, 11'd74, 10'd11, 10'd12, 10'd14, 10'd17,
			10'h222, 75, 8, 1350};
		stimTable[3] = '{11'd49, 11'd51, 11'd54, 11'd60, 10'd5, 10'd6, 10'd8, 10'd9,
			10'h300, 61, 3, 610};
		budget = 1000;
		for (int i = 0; i < 4; i++)
			budget += 3 * stimTable[i].frameLen + 100;
		watchdogCycles = budget;
		repeat (2) @(posedge vga_clk);
		reset <= 1'b0;
		checkDefaults();
		checkByteLanes();
		for (int i = 0; i < 4; i++) begin
			applyReset();
			programRow(stimTable[i]);
			measureFrame(stimTable[i]);
		end
		$display("Test OK");
		$finish;
	end

endmodule

// File: build.f
+incdir+.
vgaBusPkg.sv
vgaVideoPkg.sv
timingConfigIf.sv
vgaRegisterBank.sv
vgaSyncGenerator.sv
vgaPixelFetch.sv
vgaTop.sv
vgaTb.sv

// File: Makefile
# Verilator build and run of the VGA testbench
VERILATOR ?= verilator
TOP ?= vgaTb
FILE_LIST ?= build.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR_FLAGS ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR LOG VERILATOR_FLAGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
